//--- hw/rvConfig_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// instruction memory size in 32-bit words
`define RV_IMEM_DEPTH 256

// data memory size in 32-bit words
`define RV_DMEM_DEPTH 256

// all-ones word ends a program
`define RV_HALT_WORD 32'hFFFF_FFFF

`endif

//--- hw/rvPkg.sv
package rvPkg;

	// major opcodes, real RV32 encodings
	typedef enum logic [6:0] {
		opR      = 7'b011_0011,
		opLoad   = 7'b000_0011,
		opImm    = 7'b001_0011,
		opStore  = 7'b010_0011,
		opBranch = 7'b110_0011,
		opLui    = 7'b011_0111,
		opAuipc  = 7'b001_0111
	} opcodeE;

	typedef enum logic [2:0] {
		sInit,
		sFetch,
		sDecode,
		sExecute,
		sMemory,
		sWriteback,
		sHalt
	} cpuStateE;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluMul,
		aluPassB, // lui
		aluLt, // signed, blt
		aluEq // beq
	} aluOpE;

	typedef struct packed {
		opcodeE      op;
		aluOpE       aluOp;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [31:0] imm; // already sign extended
		logic        useImm;
		logic        writesRd;
		logic        isLoad;
		logic        isStore;
		logic        isBranch;
		logic        isHalt;
		logic        illegal;
	} decodedInstrT;

	typedef struct packed {
		logic        we;
		logic        memSel; // 0 imem, 1 dmem
		logic [7:0]  addr; // word index
		logic [31:0] wdata;
	} hostPortT;

	typedef struct packed {
		logic        we;
		logic [7:0]  addr;
		logic [31:0] wdata;
	} memReqT;

endpackage

//--- hw/wordRam.sv
`timescale 1ns/1ps

module wordRam #(
	parameter DEPTH = 256
) (
	input  logic                     CLOCK_50,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  logic [31:0]              wdata,
	output logic [31:0]              rdata
);

	logic [31:0] mem [DEPTH]; // contents come from the host port

	// write-first, read data lands one cycle after the address
	always_ff @(posedge CLOCK_50) begin
		if (we) begin
			mem[addr] <= wdata;
			rdata <= wdata; // new word seen straight away
		end else begin
			rdata <= mem[addr];
		end
	end

endmodule

//--- hw/regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic        CLOCK_50,
	input  logic        rst,
	input  logic [4:0]  rdAddrA,
	input  logic [4:0]  rdAddrB,
	output logic [31:0] rdDataA,
	output logic [31:0] rdDataB,
	input  logic        wrEn,
	input  logic [4:0]  wrAddr,
	input  logic [31:0] wrData
);

	logic [31:0] regs [32];

	// x0 reads zero whatever the array holds
	assign rdDataA = (rdAddrA == 5'd0) ? 32'd0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == 5'd0) ? 32'd0 : regs[rdAddrB];

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (wrEn && (wrAddr != 5'd0)) begin // writes to x0 dropped
			regs[wrAddr] <= wrData;
		end
	end

endmodule

//--- hw/instrDecode.sv
`timescale 1ns/1ps
`include "rvConfig_config.svh"

module instrDecode (
	input  logic [31:0]         instr,
	output rvPkg::decodedInstrT dec
);
	import rvPkg::*;

	logic [6:0]  funct7;
	logic [2:0]  funct3;
	logic [31:0] immI, immS, immB, immU;

	assign funct7 = instr[31:25];
	assign funct3 = instr[14:12];

	// immediate formats
	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {instr[31:12], 12'b0};

	always_comb begin
		dec = '0;
		dec.op = opcodeE'(instr[6:0]);
		dec.aluOp = aluAdd; // also the effective-address add
		dec.rd = instr[11:7];
		dec.rs1 = instr[19:15];
		dec.rs2 = instr[24:20];
		if (instr == `RV_HALT_WORD) begin
			dec.isHalt = 1'b1;
		end else begin
			case (instr[6:0])
				opR: begin
					dec.writesRd = 1'b1;
					if (funct3 != 3'b000) dec.illegal = 1'b1;
					case (funct7)
						7'b000_0000: dec.aluOp = aluAdd;
						7'b010_0000: dec.aluOp = aluSub;
						7'b000_0001: dec.aluOp = aluMul;
						default:     dec.illegal = 1'b1;
					endcase
				end
				opImm: begin // addi only
					{dec.useImm, dec.writesRd, dec.imm} = {2'b11, immI};
					if (funct3 != 3'b000) dec.illegal = 1'b1;
				end
				opLoad: begin // lw only
					{dec.useImm, dec.writesRd, dec.isLoad, dec.imm} = {3'b111, immI};
					if (funct3 != 3'b010) dec.illegal = 1'b1;
				end
				opStore: begin // sw only
					{dec.useImm, dec.isStore, dec.imm} = {2'b11, immS};
					if (funct3 != 3'b010) dec.illegal = 1'b1;
				end
				opBranch: begin
					dec.isBranch = 1'b1;
					dec.imm = immB; // target formed in decode, operands compared in ALU
					case (funct3)
						3'b000:  dec.aluOp = aluEq; // beq
						3'b100:  dec.aluOp = aluLt; // blt
						default: dec.illegal = 1'b1;
					endcase
				end
				opLui: {dec.aluOp, dec.useImm, dec.writesRd, dec.imm} = {aluPassB, 2'b11, immU};
				opAuipc: {dec.useImm, dec.writesRd, dec.imm} = {2'b11, immU}; // pc added in core
				default: dec.illegal = 1'b1;
			endcase
			if (dec.illegal) begin
				// no-op, nothing written anywhere
				{dec.writesRd, dec.isLoad, dec.isStore, dec.isBranch} = 4'b0;
			end
		end
	end

endmodule

//--- hw/rvCore.sv
`timescale 1ns/1ps

module rvCore (
	input  logic          CLOCK_50,
	input  logic          rst,
	output logic [7:0]    pc, // word index into imem
	input  logic [31:0]   instrWord,
	output rvPkg::memReqT memReq,
	input  logic [31:0]   memRdata,
	output logic          done,
	output logic [31:0]   clockCount,
	output logic [31:0]   instrCount
);
	import rvPkg::*;

	cpuStateE     state;
	decodedInstrT dec;
	logic [31:0]  pcReg; // byte address of next fetch
	logic [31:0]  instrPc; // byte address of the instruction in ir
	logic [31:0]  ir, aluOut, mdr, opA, opB;
	logic [31:0]  rs1Data, rs2Data;
	logic [31:0]  aluA, aluB, aluResult;
	logic         taken, lateWrite, rfWrEn;
	logic [31:0]  rfWrData;

	instrDecode decode_i (
		.instr(ir),
		.dec  (dec)
	);

	regFile regs_i (
		.CLOCK_50(CLOCK_50),
		.rst     (rst),
		.rdAddrA (dec.rs1),
		.rdAddrB (dec.rs2),
		.rdDataA (rs1Data),
		.rdDataB (rs2Data),
		.wrEn    (rfWrEn),
		.wrAddr  (dec.rd),
		.wrData  (rfWrData)
	);

	assign aluA = (dec.op == opAuipc) ? instrPc : opA;
	assign aluB = dec.useImm ? dec.imm : opB;

	always_comb begin
		case (dec.aluOp)
			aluAdd:   aluResult = aluA + aluB;
			aluSub:   aluResult = aluA - aluB;
			aluMul:   aluResult = aluA * aluB; // low 32 bits
			aluPassB: aluResult = aluB;
			aluLt:    aluResult = {31'd0, $signed(aluA) < $signed(aluB)};
			aluEq:    aluResult = {31'd0, aluA == aluB};
			default:  aluResult = aluA + aluB;
		endcase
	end

	assign taken = (state == sExecute) && dec.isBranch && aluResult[0];
	// imem reads a cycle ahead, so a taken branch presents its target now
	assign pc = taken ? aluOut[9:2] : pcReg[9:2];
	assign lateWrite = dec.isLoad || (dec.op == opAuipc); // these go through sWriteback

	// lw address leaves in execute so the word is back by sMemory
	always_comb begin
		memReq.we = (state == sMemory) && dec.isStore;
		memReq.addr = (state == sExecute) ? aluResult[9:2] : aluOut[9:2];
		memReq.wdata = opB; // rs2 for sw
	end

	assign rfWrEn = ((state == sMemory) && dec.writesRd && !lateWrite) || (state == sWriteback);
	assign rfWrData = (state == sWriteback) ? mdr : aluOut;

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			state <= sInit;
			pcReg <= 32'd0;
			done <= 1'b0;
			clockCount <= 32'd0;
			instrCount <= 32'd0;
		end else begin
			if (!done) clockCount <= clockCount + 32'd1; // freezes once halted
			case (state)
				sInit: state <= sFetch;
				sFetch: begin
					pcReg <= pcReg + 32'd4;
					state <= sDecode;
				end
				sDecode: begin
					if (dec.isHalt) begin
						state <= sHalt;
						done <= 1'b1;
					end else begin
						state <= sExecute;
					end
				end
				sExecute: begin
					instrCount <= instrCount + 32'd1; // illegal ones count too
					if (taken) pcReg <= aluOut;
					state <= (dec.isBranch || dec.illegal) ? sFetch : sMemory;
				end
				sMemory: state <= lateWrite ? sWriteback : sFetch;
				sWriteback: state <= sFetch;
				sHalt: state <= sHalt; // left only by reset
				default: state <= sInit;
			endcase
		end
	end

	// datapath registers
	always_ff @(posedge CLOCK_50) begin
		case (state)
			sFetch: begin
				ir <= instrWord;
				instrPc <= pcReg;
			end
			sDecode: begin
				opA <= rs1Data;
				opB <= rs2Data;
				aluOut <= instrPc + dec.imm; // branch target
			end
			sExecute: if (!dec.isBranch) aluOut <= aluResult; // keep target for branches
			sMemory: mdr <= dec.isLoad ? memRdata : aluOut;
			default: ;
		endcase
	end

endmodule

//--- hw/rvSystem.sv
`timescale 1ns/1ps
`include "rvConfig_config.svh"

module rvSystem (
	input  logic            CLOCK_50,
	input  logic            rst,
	input  rvPkg::hostPortT host,
	output logic [31:0]     hostRdata,
	output logic            done,
	output logic [31:0]     clockCount,
	output logic [31:0]     instrCount,
	output logic [9:0]      LEDR
);
	import rvPkg::*;

	memReqT      memReq;
	logic [7:0]  corePc;
	logic [31:0] imemRdata, dmemRdata;
	logic        imemWe, dmemWe;
	logic [7:0]  imemAddr, dmemAddr;
	logic [31:0] dmemWdata;

	// host owns imem during reset, core afterwards
	assign imemWe = rst && host.we && !host.memSel;
	assign imemAddr = rst ? host.addr : corePc;

	// host owns dmem during reset and again once done
	assign dmemWe = rst ? (host.we && host.memSel) : (!done && memReq.we);
	assign dmemAddr = (rst || done) ? host.addr : memReq.addr;
	assign dmemWdata = rst ? host.wdata : memReq.wdata;

	assign hostRdata = dmemRdata; // readback one cycle after addr
	assign LEDR = {instrCount[8:0], done};

	rvCore core_i (
		.CLOCK_50  (CLOCK_50),
		.rst       (rst),
		.pc        (corePc),
		.instrWord (imemRdata),
		.memReq    (memReq),
		.memRdata  (dmemRdata),
		.done      (done),
		.clockCount(clockCount),
		.instrCount(instrCount)
	);

	wordRam #(.DEPTH(`RV_IMEM_DEPTH)) imemRam (
		.CLOCK_50(CLOCK_50),
		.we      (imemWe),
		.addr    (imemAddr),
		.wdata   (host.wdata),
		.rdata   (imemRdata)
	);

	wordRam #(.DEPTH(`RV_DMEM_DEPTH)) dmemRam (
		.CLOCK_50(CLOCK_50),
		.we      (dmemWe),
		.addr    (dmemAddr),
		.wdata   (dmemWdata),
		.rdata   (dmemRdata)
	);

endmodule

//--- dv/rvIsaModel.sv
`timescale 1ns/1ps
`include "rvConfig_config.svh"

module rvIsaModel;

	typedef enum int {kAdd, kSub, kMul, kAddi, kLw, kSw, kLui, kAuipc, kBeq, kBlt} kindE;

	localparam int DumpBase = `RV_DMEM_DEPTH - 32; // register dump area at the top

	logic [31:0] prog [`RV_IMEM_DEPTH]; // encoded words for the DUT
	kindE        kind [`RV_IMEM_DEPTH];
	logic [4:0]  rdF [`RV_IMEM_DEPTH];
	logic [4:0]  rs1F [`RV_IMEM_DEPTH];
	logic [4:0]  rs2F [`RV_IMEM_DEPTH];
	logic [31:0] immF [`RV_IMEM_DEPTH];
	logic [31:0] dmemInit [`RV_DMEM_DEPTH]; // preload image
	logic [31:0] dmem [`RV_DMEM_DEPTH]; // contents after the run
	logic [31:0] regs [32];
	int          haltIdx; // word index of the halt
	int          retired;
	int          cycles; // expected clockCount at done

	// instruction mix per test kind
	function automatic bit allowed(input int mode, input kindE k);
		case (mode)
			1: return k inside {kAddi, kLw, kSw};
			2: return k inside {kAdd, kAddi, kBeq, kBlt};
			default: return k inside {kAdd, kSub, kMul, kAddi, kLui, kAuipc};
		endcase
	endfunction

	// RV32 encodings written out by format
	function automatic logic [31:0] encode(input int i);
		logic [31:0] m;
		m = immF[i];
		case (kind[i])
			kAdd:    return {7'h00, rs2F[i], rs1F[i], 3'b000, rdF[i], 7'h33};
			kSub:    return {7'h20, rs2F[i], rs1F[i], 3'b000, rdF[i], 7'h33};
			kMul:    return {7'h01, rs2F[i], rs1F[i], 3'b000, rdF[i], 7'h33};
			kAddi:   return {m[11:0], rs1F[i], 3'b000, rdF[i], 7'h13};
			kLw:     return {m[11:0], rs1F[i], 3'b010, rdF[i], 7'h03};
			kSw:     return {m[11:5], rs2F[i], rs1F[i], 3'b010, m[4:0], 7'h23};
			kLui:    return {m[31:12], rdF[i], 7'h37};
			kAuipc:  return {m[31:12], rdF[i], 7'h17};
			kBeq:    return {m[12], m[10:5], rs2F[i], rs1F[i], 3'b000, m[4:1], m[11], 7'h63};
			default: return {m[12], m[10:5], rs2F[i], rs1F[i], 3'b100, m[4:1], m[11], 7'h63};
		endcase
	endfunction

	task automatic genProgram(input int mode, input int len);
		logic [31:0] r;
		kindE        k;
		int          regMax;
		regMax = (mode == 2) ? 3 : 31; // few registers so branch operands often match
		haltIdx = (len > 0) ? len + 32 : 0;
		for (int i = 0; i < len; i++) begin
			do begin
				k = kindE'($urandom_range(0, 9));
			end while (!allowed(mode, k));
			r = $urandom;
			kind[i] = k;
			rdF[i] = $urandom_range(0, regMax);
			rs1F[i] = $urandom_range(0, regMax);
			rs2F[i] = $urandom_range(0, regMax);
			if (mode == 3 && r[0]) rdF[i] = 5'd0; // x0 as target half the time
			case (k)
				kAddi: immF[i] = (mode == 2) ? $urandom_range(0, 4) - 2 : {{20{r[31]}}, r[31:20]};
				kLw, kSw: begin
					rs1F[i] = 5'd0; // x0 base, word aligned offset
					immF[i] = $urandom_range(0, `RV_DMEM_DEPTH - 1) * 4;
				end
				kLui, kAuipc: immF[i] = {r[31:12], 12'b0};
				kBeq, kBlt: immF[i] = $urandom_range(1, haltIdx - i) * 4; // forward only
				default: immF[i] = 32'd0;
			endcase
		end
		if (len > 0) begin
			for (int j = 0; j < 32; j++) begin // sw xj into the dump area
				kind[len + j] = kSw;
				rs1F[len + j] = 5'd0;
				rs2F[len + j] = j[4:0];
				rdF[len + j] = 5'd0;
				immF[len + j] = (DumpBase + j) * 4;
			end
		end
		for (int i = 0; i < haltIdx; i++) prog[i] = encode(i);
		prog[haltIdx] = `RV_HALT_WORD;
		for (int a = 0; a < `RV_DMEM_DEPTH; a++) begin
			dmemInit[a] = $urandom;
			dmem[a] = dmemInit[a];
		end
	endtask

	function automatic void setReg(input logic [4:0] r, input logic [31:0] v);
		if (r != 5'd0) regs[r] = v; // x0 stays zero
	endfunction

	// one instruction at a time, cycles per class
	task automatic runProgram();
		int          pc;
		int          next;
		logic [31:0] a, b, addr;
		pc = 0;
		retired = 0;
		cycles = 3; // sInit, then fetch and decode of the halt
		for (int r = 0; r < 32; r++) regs[r] = 32'd0;
		while (pc < haltIdx) begin
			a = regs[rs1F[pc]];
			b = regs[rs2F[pc]];
			addr = a + immF[pc];
			next = pc + 1;
			retired++;
			cycles += 4;
			case (kind[pc])
				kAdd:  setReg(rdF[pc], a + b);
				kSub:  setReg(rdF[pc], a - b);
				kMul:  setReg(rdF[pc], a * b); // low word
				kAddi: setReg(rdF[pc], addr);
				kLui:  setReg(rdF[pc], immF[pc]);
				kSw:   dmem[addr[9:2]] = b;
				kLw: begin
					setReg(rdF[pc], dmem[addr[9:2]]);
					cycles++; // writeback cycle
				end
				kAuipc: begin
					setReg(rdF[pc], pc * 4 + immF[pc]);
					cycles++;
				end
				default: begin // beq, blt
					if (kind[pc] == kBeq ? (a == b) : ($signed(a) < $signed(b))) begin
						next = pc + (immF[pc] >> 2);
					end
					cycles--; // no memory cycle
				end
			endcase
			pc = next;
		end
	endtask

endmodule

//--- dv/rvSystemTb.sv
`timescale 1ns/1ps
`include "rvConfig_config.svh"

module rvSystemTb;
	import rvPkg::*;

	logic        CLOCK_50;
	logic        rst;
	hostPortT    host;
	logic [31:0] hostRdata, clockCount, instrCount;
	logic        done;
	logic [9:0]  LEDR;
	int          cycleCnt = 0;
	int          cycleLimit = 1000; // grows as each test is modelled

	rvSystem rvSystem_i (
		.CLOCK_50  (CLOCK_50),
		.rst       (rst),
		.host      (host),
		.hostRdata (hostRdata),
		.done      (done),
		.clockCount(clockCount),
		.instrCount(instrCount),
		.LEDR      (LEDR)
	);

	rvIsaModel model ();

	initial begin
		CLOCK_50 = 1'b0;
		forever #10 CLOCK_50 = ~CLOCK_50; // 50 MHz
	end

	always @(posedge CLOCK_50) begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt > cycleLimit) begin
			$display("the run took more clock cycles than the tests should need");
			$display("Simulation failed");
			$fatal(1, "timeout");
		end
	end

	task automatic checkWord(input string testName, input logic [31:0] expV, input logic [31:0] actV);
		if (actV !== expV) begin
			$display("ERR %s expected %h actual %h", testName, expV, actV);
			$display("Simulation failed");
			$fatal(1, "data word mismatch");
		end
	endtask

	task automatic checkCount(input string testName, input logic [31:0] expV, input logic [31:0] actV);
		if (actV !== expV) begin
			$display("ERR %s expected %0d actual %0d", testName, expV, actV);
			$display("Simulation failed");
			$fatal(1, "counter mismatch");
		end
	endtask

	task automatic checkFlag(input string testName, input logic expV, input logic actV);
		if (actV !== expV) begin
			$display("ERR %s expected %b actual %b", testName, expV, actV);
			$display("Simulation failed");
			$fatal(1, "flag mismatch");
		end
	endtask

	task automatic hostWrite(input logic sel, input logic [7:0] addr, input logic [31:0] data);
		host.we = 1'b1;
		host.memSel = sel;
		host.addr = addr;
		host.wdata = data;
		@(negedge CLOCK_50);
		host.we = 1'b0;
	endtask

	// reset and load, run to done, then read dmem back
	task automatic runTest(input string testName, input int mode, input int len);
		model.genProgram(mode, len);
		model.runProgram();
		cycleLimit += 2 * (8 + model.haltIdx + 1 + 2 * `RV_DMEM_DEPTH + model.cycles);
		@(negedge CLOCK_50);
		rst = 1'b1;
		@(negedge CLOCK_50);
		checkFlag({testName, " done cleared by reset"}, 1'b0, done);
		repeat (7) @(negedge CLOCK_50); // 8 cycles of reset before loading
		for (int i = 0; i <= model.haltIdx; i++) hostWrite(1'b0, i[7:0], model.prog[i]);
		for (int i = 0; i < `RV_DMEM_DEPTH; i++) hostWrite(1'b1, i[7:0], model.dmemInit[i]);
		rst = 1'b0;
		@(negedge CLOCK_50);
		checkFlag({testName, " done low after reset"}, 1'b0, done);
		while (done !== 1'b1) @(negedge CLOCK_50); // watchdog bounds this
		checkCount({testName, " instrCount"}, model.retired, instrCount);
		checkCount({testName, " clockCount"}, model.cycles, clockCount);
		checkFlag({testName, " LEDR done"}, 1'b1, LEDR[0]);
		// upper LEDR bits mirror the low nine bits of the retired count
		checkCount({testName, " LEDR count"}, model.retired % 512, {23'd0, LEDR[9:1]});
		for (int i = 0; i < `RV_DMEM_DEPTH; i++) begin
			host.addr = i[7:0];
			@(negedge CLOCK_50); // word back one cycle later
			checkWord($sformatf("%s dmem[%0d]", testName, i), model.dmem[i], hostRdata);
		end
		checkFlag({testName, " done held"}, 1'b1, done);
		checkCount({testName, " clockCount held"}, model.cycles, clockCount);
	endtask

	initial begin
		void'($urandom(32'h321e_89aa));
		rst = 1'b1;
		host = '0;
		runTest("haltOnly", 0, 0);
		repeat (3) begin
			runTest("arith", 0, 60);
			runTest("loadStore", 1, 60);
			runTest("branch", 2, 60);
			runTest("x0", 3, 40);
		end
		runTest("haltAgain", 0, 0); // done must drop again after a full run
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- rvSystem.f
+incdir+hw
hw/rvPkg.sv
hw/wordRam.sv
hw/regFile.sv
hw/instrDecode.sv
hw/rvCore.sv
hw/rvSystem.sv
dv/rvIsaModel.sv
dv/rvSystemTb.sv

//--- Bender.yml
package:
  name: rvSystem

sources:
  - include_dirs:
      - hw
    files:
      - hw/rvPkg.sv
      - hw/wordRam.sv
      - hw/regFile.sv
      - hw/instrDecode.sv
      - hw/rvCore.sv
      - hw/rvSystem.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/rvIsaModel.sv
      - dv/rvSystemTb.sv
